// File: include/msx_mem_macros.svh
`ifndef MSX_MEM_MACROS_SVH
`define MSX_MEM_MACROS_SVH

// byte addressed memory space shared by all masters
`define MEM_ADDR_W 27

// one byte per access
`define MEM_DATA_W 8

// 256 KiB of block RAM unless the top says otherwise
`define BRAM_WIDTH_DEFAULT 18

`endif

// File: rtl/msx_mem_pkg.sv
`include "msx_mem_macros.svh"

package msx_mem_pkg;

    // full byte address as seen by a bus master
    typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;

    typedef logic [`MEM_DATA_W-1:0] mem_data_t; // one data byte

    // loader FSM
    typedef enum logic [1:0] {
        LD_IDLE,      // upload low
        LD_WAIT_BYTE, // waiting for a strobe
        LD_WRITE      // write in flight
    } loader_state_t;

endpackage

// File: rtl/system_bram.sv
`include "msx_mem_macros.svh"

module system_bram #(
    parameter int BRAM_WIDTH = `BRAM_WIDTH_DEFAULT
) (
    input  logic                   clk,
    input  logic [BRAM_WIDTH-1:0]  addr,
    input  logic                   we,
    input  msx_mem_pkg::mem_data_t wdata,
    output msx_mem_pkg::mem_data_t rdata
);
    import msx_mem_pkg::*;

    mem_data_t mem [2**BRAM_WIDTH];

    // single port RAM returning the old byte on a collision
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr]; // registered every cycle
    end

endmodule

// File: rtl/upload_loader.sv
`include "msx_mem_macros.svh"

module upload_loader (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   upload,
    input  logic                   byte_valid,
    input  msx_mem_pkg::mem_data_t byte_data,
    output logic                   busy,
    output msx_mem_pkg::mem_addr_t addr,
    output msx_mem_pkg::mem_data_t data,
    output logic                   rnw,
    output logic                   cs,
    input  logic                   done
);
    import msx_mem_pkg::*;

    loader_state_t state;
    mem_data_t     byte_r;
    mem_addr_t     addr_r;

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= LD_IDLE;
            addr_r <= '0;
        end else if (!upload) begin
            state  <= LD_IDLE; // next upload starts again at address 0
            addr_r <= '0;
        end else begin
            case (state)
                LD_IDLE: begin
                    state <= LD_WAIT_BYTE;
                end
                LD_WAIT_BYTE: begin
                    if (byte_valid) begin
                        state <= LD_WRITE;
                    end
                end
                LD_WRITE: begin
                    if (done) begin
                        state  <= LD_WAIT_BYTE;
                        addr_r <= addr_r + 1'b1;
                    end
                end
                default: begin
                    state <= LD_IDLE;
                end
            endcase
        end
    end

    // payload byte taken with the strobe
    always_ff @(posedge clk) begin
        if (state == LD_WAIT_BYTE && byte_valid) begin
            byte_r <= byte_data;
        end
    end

    // strobes seen in LD_WRITE are dropped
    assign busy = (state == LD_WRITE);
    assign cs   = (state == LD_WRITE);
    assign rnw  = 1'b0; // loader only writes
    assign addr = addr_r;
    assign data = byte_r;

endmodule

// File: rtl/system_memory.sv
`include "msx_mem_macros.svh"

module system_memory #(
    parameter int BRAM_WIDTH = `BRAM_WIDTH_DEFAULT
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   upload,

    input  msx_mem_pkg::mem_addr_t msx_addr,
    input  msx_mem_pkg::mem_data_t msx_data,
    input  logic                   msx_rnw,
    input  logic                   msx_cs,
    output msx_mem_pkg::mem_data_t msx_q,
    output logic                   msx_done,
    output logic                   msx_ready,

    input  msx_mem_pkg::mem_addr_t up_addr,
    input  msx_mem_pkg::mem_data_t up_data,
    input  logic                   up_rnw,
    input  logic                   up_cs,
    output msx_mem_pkg::mem_data_t up_q,
    output logic                   up_done,
    output logic                   up_ready,

    output msx_mem_pkg::mem_addr_t sdram_addr,
    output msx_mem_pkg::mem_data_t sdram_data,
    output logic                   sdram_rnw,
    output logic                   sdram_cs,
    input  msx_mem_pkg::mem_data_t sdram_q,
    input  logic                   sdram_ready,
    input  logic                   sdram_done
);
    import msx_mem_pkg::*;

    mem_addr_t addr;
    mem_data_t data;
    mem_data_t q;
    mem_data_t bram_rdata;
    logic      rnw;
    logic      cs;
    logic      bram_cs;
    logic      bram_active;
    logic      bram_done;
    logic      owner_done;

    assign addr = upload ? up_addr : msx_addr; // loader owns memory while uploading
    assign data = upload ? up_data : msx_data;
    assign rnw  = upload ? up_rnw  : msx_rnw;
    assign cs   = upload ? up_cs   : msx_cs;

    generate
        if (BRAM_WIDTH == 0) begin : g_sdram_only
            assign bram_cs    = 1'b0;
            assign sdram_cs   = cs;
            assign sdram_addr = addr;
            assign bram_rdata = '1; // nothing behind the block RAM region
        end else begin : g_bram
            logic bram_we;

            assign bram_cs    = cs && (addr[`MEM_ADDR_W-1:BRAM_WIDTH] == '0);
            assign sdram_cs   = cs && (addr[`MEM_ADDR_W-1:BRAM_WIDTH] != '0);
            assign sdram_addr = addr - (mem_addr_t'(1) << BRAM_WIDTH); // sdram starts at 0
            assign bram_we    = bram_cs && !rnw && !bram_active; // first edge only

            system_bram #(
                .BRAM_WIDTH(BRAM_WIDTH)
            ) u_bram (
                .clk  (clk),
                .addr (addr[BRAM_WIDTH-1:0]),
                .we   (bram_we),
                .wdata(data),
                .rdata(bram_rdata)
            );
        end
    endgenerate

    // set on the first edge of a block RAM access, cleared on the done edge
    always_ff @(posedge clk) begin
        if (reset) begin
            bram_active <= 1'b0;
        end else begin
            bram_active <= bram_cs && !bram_active;
        end
    end

    assign bram_done  = bram_cs && bram_active;
    assign owner_done = bram_done || (sdram_cs && sdram_done);
    assign q          = bram_cs ? bram_rdata : sdram_q;

    assign sdram_data = data;
    assign sdram_rnw  = rnw;

    assign msx_q     = (!upload && msx_cs) ? q : '1;
    assign msx_done  = !upload && owner_done;
    assign msx_ready = sdram_ready;

    assign up_q     = (upload && up_cs) ? q : '1;
    assign up_done  = upload && owner_done;
    assign up_ready = sdram_ready;

endmodule

// File: rtl/msx_memory_top.sv
`include "msx_mem_macros.svh"

module msx_memory_top #(
    parameter int BRAM_WIDTH = `BRAM_WIDTH_DEFAULT
) (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   upload,
    input  logic                   byte_valid,
    input  msx_mem_pkg::mem_data_t byte_data,
    output logic                   busy,

    input  msx_mem_pkg::mem_addr_t msx_addr,
    input  msx_mem_pkg::mem_data_t msx_data,
    input  logic                   msx_rnw,
    input  logic                   msx_cs,
    output msx_mem_pkg::mem_data_t msx_q,
    output logic                   msx_done,
    output logic                   msx_ready,

    output msx_mem_pkg::mem_addr_t sdram_addr,
    output msx_mem_pkg::mem_data_t sdram_data,
    output logic                   sdram_rnw,
    output logic                   sdram_cs,
    input  msx_mem_pkg::mem_data_t sdram_q,
    input  logic                   sdram_ready,
    input  logic                   sdram_done
);
    import msx_mem_pkg::*;

    mem_addr_t up_addr;
    mem_data_t up_data;
    logic      up_rnw;
    logic      up_cs;
    logic      up_done;

    upload_loader u_loader (
        .clk       (clk),
        .reset     (reset),
        .upload    (upload),
        .byte_valid(byte_valid),
        .byte_data (byte_data),
        .busy      (busy),
        .addr      (up_addr),
        .data      (up_data),
        .rnw       (up_rnw),
        .cs        (up_cs),
        .done      (up_done)
    );

    system_memory #(
        .BRAM_WIDTH(BRAM_WIDTH)
    ) u_memory (
        .clk        (clk),
        .reset      (reset),
        .upload     (upload),
        .msx_addr   (msx_addr),
        .msx_data   (msx_data),
        .msx_rnw    (msx_rnw),
        .msx_cs     (msx_cs),
        .msx_q      (msx_q),
        .msx_done   (msx_done),
        .msx_ready  (msx_ready),
        .up_addr    (up_addr),
        .up_data    (up_data),
        .up_rnw     (up_rnw),
        .up_cs      (up_cs),
        .up_q       (),          // loader never reads back
        .up_done    (up_done),
        .up_ready   (),
        .sdram_addr (sdram_addr),
        .sdram_data (sdram_data),
        .sdram_rnw  (sdram_rnw),
        .sdram_cs   (sdram_cs),
        .sdram_q    (sdram_q),
        .sdram_ready(sdram_ready),
        .sdram_done (sdram_done)
    );

endmodule

// File: bench/msx_memory_assert.sv
module msx_memory_assert #(
    parameter int BRAM_WIDTH = 10
) (
    input logic                   clk,
    input logic                   reset,
    input logic                   upload,
    input logic                   msx_cs,
    input logic                   msx_done,
    input logic                   up_cs,
    input logic                   up_done,
    input logic                   sdram_cs,
    input msx_mem_pkg::mem_addr_t sdram_addr,
    input msx_mem_pkg::mem_addr_t owner_addr,
    input logic                   owner_rnw
);
    timeunit 1ns;
    timeprecision 100ps;
    import msx_mem_pkg::*;

    // sdram sees addresses from zero above the block RAM
    localparam mem_addr_t SDRAM_BASE = mem_addr_t'((BRAM_WIDTH == 0) ? 0 : (1 << BRAM_WIDTH));

    int fail_count = 0;

    no_double_write: assert property (@(posedge clk) disable iff (reset)
        !(sdram_cs && !owner_rnw && (owner_addr < SDRAM_BASE)))
        else begin
            $error("sdram_cs active during a block RAM write");
            fail_count++;
        end

    msx_done_owned: assert property (@(posedge clk) disable iff (reset)
        msx_done |-> (!upload && msx_cs && !$past(msx_done)))
        else begin
            $error("msx_done without an msx request or longer than one cycle");
            fail_count++;
        end

    up_done_owned: assert property (@(posedge clk) disable iff (reset)
        up_done |-> (upload && up_cs && !$past(up_done)))
        else begin
            $error("up_done without a loader request or longer than one cycle");
            fail_count++;
        end

    sdram_rebase: assert property (@(posedge clk) disable iff (reset)
        sdram_cs |-> (sdram_addr == owner_addr - SDRAM_BASE))
        else begin
            $error("sdram_addr not rebased from the owner address");
            fail_count++;
        end

endmodule

bind system_memory msx_memory_assert #(
    .BRAM_WIDTH(BRAM_WIDTH)
) u_assert (
    .clk        (clk),
    .reset      (reset),
    .upload     (upload),
    .msx_cs     (msx_cs),
    .msx_done   (msx_done),
    .up_cs      (up_cs),
    .up_done    (up_done),
    .sdram_cs   (sdram_cs),
    .sdram_addr (sdram_addr),
    .owner_addr (addr),
    .owner_rnw  (rnw)
);

// File: bench/msx_memory_tb.sv
module msx_memory_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import msx_mem_pkg::*;

    localparam int BRAM_WIDTH = 10;
    localparam mem_addr_t BRAM_SIZE = mem_addr_t'(1 << BRAM_WIDTH);
    localparam int TIMEOUT = 200;

    logic      clk;
    logic      reset;
    logic      upload;
    logic      byte_valid;
    mem_data_t byte_data;
    logic      busy;
    mem_addr_t msx_addr;
    mem_data_t msx_data;
    logic      msx_rnw;
    logic      msx_cs;
    mem_data_t msx_q;
    logic      msx_done;
    logic      msx_ready;
    mem_addr_t sdram_addr;
    mem_data_t sdram_data;
    logic      sdram_rnw;
    logic      sdram_cs;
    mem_data_t sdram_q;
    logic      sdram_ready;
    logic      sdram_done;

    logic [31:0] rng_state;
    int          errors;
    int          timeouts;
    mem_addr_t   load_addr;
    mem_data_t   sdram_mem [mem_addr_t]; // sparse sdram contents
    mem_data_t   ref_mem [mem_addr_t];   // expected contents by full address
    mem_addr_t   ignored_q [$];

    msx_memory_top #(
        .BRAM_WIDTH(BRAM_WIDTH)
    ) u_dut (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // power-up content of sdram from every address bit
    function automatic mem_data_t fill_byte(mem_addr_t a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ {5'b0, a[26:24]} ^ 8'h5a;
    endfunction

    function automatic mem_addr_t random_addr();
        logic [31:0] r;
        r = next_random();
        if (r[30:28] == 3'd0) begin
            return r[26:0]; // anywhere in the space
        end
        if (r[31]) begin
            return mem_addr_t'(r[9:0]);
        end
        return BRAM_SIZE + mem_addr_t'(r[12:0]);
    endfunction

    task automatic end_run();
        int asserts;
        asserts = u_dut.u_memory.u_assert.fail_count;
        $display("errors %0d, timeouts %0d, assertion failures %0d", errors, timeouts, asserts);
        if (errors == 0 && timeouts == 0 && asserts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic check_equal(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (exp == got) else begin
            errors++;
            $display("ERR %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT);
        end_run();
    endtask

    task automatic check_idle();
        @(negedge clk);
        check_equal("msx_q", 32'hff, 32'(msx_q));
        check_equal("msx_done", 32'd0, 32'(msx_done));
        check_equal("msx_ready", 32'(sdram_ready), 32'(msx_ready));
    endtask

    task automatic mem_access(input mem_addr_t a, input logic rd, input mem_data_t wd);
        int        cycles;
        logic      seen;
        mem_data_t got;
        @(posedge clk);
        #2;
        msx_addr = a;
        msx_rnw  = rd;
        msx_data = wd;
        msx_cs   = 1'b1;
        cycles   = 0;
        seen     = 1'b0;
        while (!seen && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (msx_done) begin
                seen = 1'b1;
                got  = msx_q;
                check_equal("sdram_cs", 32'(a >= BRAM_SIZE), 32'(sdram_cs));
                if (a >= BRAM_SIZE) begin
                    check_equal("sdram_addr", 32'(a - BRAM_SIZE), 32'(sdram_addr));
                    check_equal("sdram_rnw", 32'(rd), 32'(sdram_rnw));
                    if (!rd) begin
                        check_equal("sdram_data", 32'(wd), 32'(sdram_data));
                    end
                end
            end
        end
        if (!seen) begin
            report_timeout("msx_done");
        end else begin
            if (a < BRAM_SIZE) begin
                check_equal("msx_done latency", 32'd2, 32'(cycles));
            end
            if (!rd) begin
                ref_mem[a] = wd;
            end else if (ref_mem.exists(a)) begin
                check_equal("msx_q", 32'(ref_mem[a]), 32'(got));
            end else if (a >= BRAM_SIZE) begin
                check_equal("msx_q", 32'(fill_byte(a - BRAM_SIZE)), 32'(got));
            end
        end
        @(posedge clk);
        #2;
        msx_cs = 1'b0;
        check_idle();
    endtask

    task automatic random_access();
        logic [31:0] r;
        mem_addr_t   a;
        a = random_addr();
        r = next_random();
        mem_access(a, r[0], r[15:8]);
    endtask

    // waits for the loader to finish while msx stays silent
    task automatic wait_loader_idle();
        int cycles;
        cycles = 0;
        @(negedge clk);
        check_equal("msx_done", 32'd0, 32'(msx_done));
        while (busy && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            check_equal("msx_done", 32'd0, 32'(msx_done));
            check_equal("msx_q", 32'hff, 32'(msx_q));
        end
        if (busy) begin
            report_timeout("loader busy clear");
        end
    endtask

    task automatic send_byte(input logic expect_busy);
        logic [31:0] r;
        r = next_random();
        @(posedge clk);
        #2;
        byte_valid = 1'b1;
        byte_data  = r[7:0];
        @(negedge clk);
        check_equal("busy", 32'(expect_busy), 32'(busy));
        @(posedge clk);
        #2;
        byte_valid = 1'b0;
        if (!expect_busy) begin // a strobe seen while busy is lost
            ref_mem[load_addr] = r[7:0];
            load_addr++;
        end
    endtask

    task automatic start_upload();
        @(posedge clk);
        #2;
        upload    = 1'b1;
        load_addr = '0;
        repeat (2) @(posedge clk);
    endtask

    task automatic stop_upload();
        @(posedge clk);
        #2;
        upload = 1'b0;
        @(posedge clk);
    endtask

    // sdram channel with 1 to 6 cycles of latency
    initial begin
        int        lat;
        mem_addr_t a;
        forever begin
            @(negedge clk);
            if (sdram_cs && !reset) begin
                lat = 1 + int'(next_random() % 32'd6);
                repeat (lat) @(posedge clk);
                #2;
                a = sdram_addr;
                if (sdram_rnw) begin
                    sdram_q = sdram_mem.exists(a) ? sdram_mem[a] : fill_byte(a);
                end else begin
                    sdram_mem[a] = sdram_data;
                end
                sdram_done = 1'b1;
                @(posedge clk);
                #2;
                sdram_done = 1'b0;
            end
        end
    end

    initial begin
        logic [31:0] r;
        mem_addr_t   a;
        clk         = 1'b0;
        reset       = 1'b1;
        upload      = 1'b0;
        byte_valid  = 1'b0;
        byte_data   = '0;
        msx_addr    = '0;
        msx_data    = '0;
        msx_rnw     = 1'b1;
        msx_cs      = 1'b0;
        sdram_q     = '0;
        sdram_ready = 1'b1;
        sdram_done  = 1'b0;
        rng_state   = 32'hc4ab_83d4;
        errors      = 0;
        timeouts    = 0;
        load_addr   = '0;
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;

        check_idle();
        @(posedge clk);
        #2;
        sdram_ready = 1'b0;
        check_idle();
        @(posedge clk);
        #2;
        sdram_ready = 1'b1;
        check_idle();

        repeat (300) random_access();

        start_upload();
        repeat (1500) begin
            wait_loader_idle();
            send_byte(1'b0);
        end
        wait_loader_idle();
        stop_upload();
        for (int i = 0; i < 1500; i++) begin
            mem_access(mem_addr_t'(i), 1'b1, 8'h00);
        end

        // msx writes are ignored and the second of each strobe pair is lost
        start_upload();
        repeat (40) begin
            wait_loader_idle();
            a = random_addr();
            r = next_random();
            @(posedge clk);
            #2;
            msx_addr = a;
            msx_data = r[7:0];
            msx_rnw  = 1'b0;
            msx_cs   = 1'b1;
            ignored_q.push_back(a);
            send_byte(1'b0);
            send_byte(1'b1);
        end
        wait_loader_idle();
        @(posedge clk);
        #2;
        msx_cs = 1'b0;
        stop_upload();
        for (int i = 0; i < 60; i++) begin
            mem_access(mem_addr_t'(i), 1'b1, 8'h00);
        end
        foreach (ignored_q[i]) begin
            mem_access(ignored_q[i], 1'b1, 8'h00);
        end

        repeat (300) random_access();
        end_run();
    end

endmodule

// File: msx_memory.f
+incdir+include
rtl/msx_mem_pkg.sv
rtl/system_bram.sv
rtl/upload_loader.sv
rtl/system_memory.sv
rtl/msx_memory_top.sv
bench/msx_memory_assert.sv
bench/msx_memory_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the msx memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module msx_memory_tb -f msx_memory.f \
    --Mdir obj_dir -o msx_memory_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/msx_memory_sim +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation passed$" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1
